/* bench/tb_clock_gen.sv */
// testbench clock generator module, 8 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  // full period in ns
  parameter realtime PERIOD = 8.0
) (
  output logic clk_o
);

  // low at time zero, first rising edge after half a period
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PERIOD / 2.0);
    clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* bench/tb_noc_input_port.sv */
// testbench top with stimulus, per-channel reference queues, assertions, report and timeout
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module tb_noc_input_port;
  import noc_pkg::*;

  localparam int MAX_CYCLES = 2000;

  logic clk;
  logic rst_i;
  flit_req_t  fin_req;
  flit_resp_t fin_resp;
  flit_req_t  fout_req;
  flit_resp_t fout_resp;

  // reference model, one queue per tag value, tag 3 never filled
  flit_data_t model_q [4][$];
  logic       head_vld [4];
  flit_data_t head_data [4];
  flit_data_t exp_fdata;
  logic       exp_vld;

  // priority order expected at the output
  vc_id_t prio_exp [$];
  vc_id_t prio_head;
  logic   prio_phase;

  int   cycle_cnt;
  int   in_cnt;
  int   bp_base;
  logic bp_phase;
  logic lat_wait;
  int   lat_cyc;
  int   test_id;
  int   err_cnt;
  int   pass_cnt;
  int   fail_cnt;
  logic [31:0] rng;
  // separate stream for the link ready pattern
  logic [31:0] rdy_rng;

  logic in_hs;
  logic out_hs;

  tb_clock_gen clk_gen_i (.clk_o(clk));

  noc_input_port dut_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .fin_req_i   (fin_req),
    .fin_resp_o  (fin_resp),
    .fout_req_o  (fout_req),
    .fout_resp_i (fout_resp)
  );

  assign in_hs     = fin_req.valid && fin_resp.ready;
  assign out_hs    = fout_req.valid && fout_resp.ready;
  assign exp_fdata = head_data[fout_req.vc_id];
  assign exp_vld   = head_vld[fout_req.vc_id];

  // one xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // stimulus stream, advanced by the main process only
  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // monitor, keeps the model in step with both handshakes
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!rst_i) begin
      if (out_hs) begin
        lat_wait <= 1'b0;
        if (model_q[fout_req.vc_id].size() > 0) begin
          void'(model_q[fout_req.vc_id].pop_front());
        end
        if (prio_phase && prio_exp.size() > 0) begin
          void'(prio_exp.pop_front());
        end
      end
      if (in_hs) begin
        in_cnt <= in_cnt + 1;
        if (int'(fin_req.vc_id) < `NUM_VIRT_CHN) begin
          model_q[fin_req.vc_id].push_back(fin_req.fdata);
        end
        if (test_id == 2) begin
          lat_wait <= 1'b1;
          lat_cyc  <= cycle_cnt;
        end
      end
      for (int c = 0; c < 4; c++) begin
        head_vld[c]  = (model_q[c].size() > 0);
        head_data[c] = head_vld[c] ? model_q[c][0] : '0;
      end
      prio_head = (prio_exp.size() > 0) ? prio_exp[0] : '0;
    end
  end

  // 1: state right after reset
  reset_state_chk: assert property (@(posedge clk) $fell(rst_i) |->
      (!fout_req.valid && fin_resp.ready))
    else begin
      $display("FAILED fout_req_o.valid/fin_resp_o.ready expected 0/1 actual %h/%h",
               $sampled(fout_req.valid), $sampled(fin_resp.ready));
      err_cnt++;
    end

  // 2: two cycles from input handshake to output
  latency_chk: assert property (@(posedge clk) disable iff (rst_i)
      (lat_wait && fout_req.valid) |-> (cycle_cnt == lat_cyc + 2))
    else begin
      $display("FAILED latency cycles expected %h actual %h",
               32'd2, $sampled(cycle_cnt) - $sampled(lat_cyc));
      err_cnt++;
    end

  // 3 and 6: every output flit has a matching model entry
  known_flit_chk: assert property (@(posedge clk) disable iff (rst_i)
      out_hs |-> exp_vld)
    else begin
      $display("unexpected output flit on channel %0d, nothing was sent there",
               $sampled(fout_req.vc_id));
      err_cnt++;
    end

  fdata_chk: assert property (@(posedge clk) disable iff (rst_i)
      (out_hs && exp_vld) |-> (fout_req.fdata == exp_fdata))
    else begin
      $display("FAILED fout_req_o.fdata expected %h actual %h",
               $sampled(exp_fdata), $sampled(fout_req.fdata));
      err_cnt++;
    end

  // 4: grant order under fixed priority
  prio_chk: assert property (@(posedge clk) disable iff (rst_i)
      (prio_phase && out_hs) |-> (fout_req.vc_id == prio_head))
    else begin
      $display("FAILED fout_req_o.vc_id expected %h actual %h",
               $sampled(prio_head), $sampled(fout_req.vc_id));
      err_cnt++;
    end

  // 5: ready only drops once fifo and skid are both full
  bp_chk: assert property (@(posedge clk) disable iff (rst_i)
      (bp_phase && fin_req.valid && !fin_resp.ready) |->
      (in_cnt - bp_base == `VC_FIFO_DEPTH + 2))
    else begin
      $display("FAILED accepted flit count expected %h actual %h",
               `VC_FIFO_DEPTH + 2, $sampled(in_cnt) - $sampled(bp_base));
      err_cnt++;
    end

  // 6: unused tag is always accepted
  drop_ready_chk: assert property (@(posedge clk) disable iff (rst_i)
      (fin_req.valid && fin_req.vc_id == 2'd3) |-> fin_resp.ready)
    else begin
      $display("FAILED fin_resp_o.ready expected %h actual %h",
               1'b1, $sampled(fin_resp.ready));
      err_cnt++;
    end

  // run limit
  always @(posedge clk) begin
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // one flit, back to the caller at its handshake edge
  task automatic send_flit(input vc_id_t vc, input flit_data_t data);
    fin_req.valid <= 1'b1;
    fin_req.vc_id <= vc;
    fin_req.fdata <= data;
    @(posedge clk);
    while (!fin_resp.ready) begin
      @(posedge clk);
    end
    fin_req.valid <= 1'b0;
  endtask

  // open the link and wait for the port to go quiet
  // three idle cycles cover the bubble after a fresh fifo write
  task automatic drain();
    int idle;
    fout_resp.ready <= 1'b1;
    idle = 0;
    while (idle < 3) begin
      @(posedge clk);
      if (fout_req.valid) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
    // whatever the model still holds never came out
    drained_chk: assert (model_q[0].size() + model_q[1].size() + model_q[2].size() == 0)
      else begin
        $display("flits lost, reference queues not empty after the port went idle");
        err_cnt++;
      end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %0d %s: ok", test_id, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_id, name, err_cnt - err_before);
    end
  endtask

  initial begin
    int e;
    int stalls;
    logic rand_done;
    rst_i      = 1'b1;
    fin_req    = '0;
    fout_resp  = '0;
    prio_phase = 1'b0;
    bp_phase   = 1'b0;
    lat_wait   = 1'b0;
    lat_cyc    = 0;
    cycle_cnt  = 0;
    in_cnt     = 0;
    bp_base    = 0;
    test_id    = 0;
    err_cnt    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    rng        = 32'd99590;
    rdy_rng    = 32'd99590;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    fout_resp.ready <= 1'b1;

    // 1: checked by reset_state_chk on release
    test_id = 1;
    e = err_cnt;
    repeat (2) @(posedge clk);
    finish_test("reset state", e);

    // 2: single flit on channel 1
    test_id = 2;
    e = err_cnt;
    send_flit(2'd1, next_rand());
    drain();
    finish_test("latency", e);

    // 3: random traffic with random link stalls
    test_id = 3;
    e = err_cnt;
    rand_done = 1'b0;
    fork
      begin
        for (int n = 0; n < 200; n++) begin
          send_flit(vc_id_t'(next_rand() % `NUM_VIRT_CHN), next_rand());
        end
        rand_done = 1'b1;
      end
      begin
        while (!rand_done) begin
          rdy_rng = xorshift32(rdy_rng);
          fout_resp.ready <= rdy_rng[0];
          @(posedge clk);
        end
      end
    join
    drain();
    finish_test("channel order", e);

    // 4: ch2 pair fills the skid, then ch0 and ch1 wait in fifos
    test_id = 4;
    e = err_cnt;
    fout_resp.ready <= 1'b0;
    send_flit(2'd2, next_rand());
    send_flit(2'd2, next_rand());
    send_flit(2'd0, next_rand());
    send_flit(2'd0, next_rand());
    send_flit(2'd1, next_rand());
    send_flit(2'd1, next_rand());
    repeat (3) @(posedge clk);
    prio_exp   = '{2'd2, 2'd2, 2'd1, 2'd1, 2'd0, 2'd0};
    prio_head  = 2'd2;
    prio_phase = 1'b1;
    drain();
    prio_phase = 1'b0;
    finish_test("priority", e);

    // 5: one channel against a stalled link
    test_id = 5;
    e = err_cnt;
    fout_resp.ready <= 1'b0;
    bp_base  = in_cnt;
    bp_phase = 1'b1;
    stalls   = 0;
    fin_req.valid <= 1'b1;
    fin_req.vc_id <= 2'd1;
    fin_req.fdata <= next_rand();
    while (stalls < 4) begin
      @(posedge clk);
      if (fin_resp.ready) begin
        fin_req.fdata <= next_rand();
      end else begin
        stalls++;
      end
    end
    fin_req.valid <= 1'b0;
    @(posedge clk);
    bp_phase = 1'b0;
    drain();
    finish_test("back-pressure", e);

    // 6: tag 3 is swallowed, tagged flits around it still pass
    test_id = 6;
    e = err_cnt;
    for (int n = 0; n < 5; n++) begin
      send_flit(2'd3, next_rand());
      send_flit(vc_id_t'(n % `NUM_VIRT_CHN), next_rand());
    end
    drain();
    finish_test("unused channel", e);

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the input port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_noc_input_port \
  -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi

echo "pass message not found in $LOG"
exit 1

/* sources.f */
+incdir+verilog
verilog/noc_pkg.sv
verilog/vc_buffer.sv
verilog/input_datapath.sv
verilog/flit_skid_buffer.sv
verilog/noc_input_port.sv
bench/tb_clock_gen.sv
bench/tb_noc_input_port.sv

/* verilog/flit_skid_buffer.sv */
// two-entry flit skid buffer module with registered output and registered ready
`timescale 1ns/1ps
`default_nettype none

module flit_skid_buffer (
  input  logic                clk,
  input  logic                rst_i,
  // upstream side
  input  noc_pkg::flit_req_t  in_req_i,
  output noc_pkg::flit_resp_t in_resp_o,
  // link side
  output noc_pkg::flit_req_t  out_req_o,
  input  noc_pkg::flit_resp_t out_resp_i
);
  import noc_pkg::*;

  // occupancy of the spare register
  typedef enum logic {
    skid_empty_e,
    skid_full_e
  } skid_state_t;

  skid_state_t state_q;

  // main drives the link, spare catches a stalled arrival
  flit_req_t main_q;
  flit_req_t spare_q;

  logic in_fire;
  logic out_fire;
  logic main_free;

  // ready comes straight from a flop
  assign in_resp_o.ready = (state_q == skid_empty_e);

  assign in_fire  = in_req_i.valid && in_resp_o.ready;
  assign out_fire = main_q.valid && out_resp_i.ready;

  // main can take a new flit when idle or draining
  assign main_free = !main_q.valid || out_resp_i.ready;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q      <= skid_empty_e;
      main_q.valid <= 1'b0;
    end else begin
      case (state_q)
        skid_empty_e: begin
          if (in_fire) begin
            if (main_free) begin
              // normal flow, straight into main
              main_q <= in_req_i;
            end else begin
              // link stalled, park it in spare
              spare_q <= in_req_i;
              state_q <= skid_full_e;
            end
          end else if (out_fire) begin
            main_q.valid <= 1'b0;
          end
        end
        skid_full_e: begin
          // main is always valid here
          // refill from spare once the link takes it
          if (out_fire) begin
            main_q  <= spare_q;
            state_q <= skid_empty_e;
          end
        end
        default: state_q <= skid_empty_e;
      endcase
    end
  end

  // link side, all from flops
  assign out_req_o = main_q;

endmodule

`default_nettype wire

/* verilog/input_datapath.sv */
// input datapath module with channel demux, virtual channel fifos and priority output mux
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module input_datapath (
  input  logic                clk,
  input  logic                rst_i,
  // from the external sender
  input  noc_pkg::flit_req_t  fin_req_i,
  output noc_pkg::flit_resp_t fin_resp_o,
  // toward the output stage
  output noc_pkg::flit_req_t  fout_req_o,
  input  noc_pkg::flit_resp_t fout_resp_i
);
  import noc_pkg::*;

  // arbitration direction as a plain bit
  localparam bit HIGH_PRIO_TOP = (`HIGH_PRIO_ZERO_LOW != 0);

  // demux side, one lane per channel
  logic [`NUM_VIRT_CHN-1:0] demux_valid;
  logic [`NUM_VIRT_CHN-1:0] demux_ready;

  // fifo heads and per-channel ready back from the mux
  flit_req_t [`NUM_VIRT_CHN-1:0] to_output_req;
  logic      [`NUM_VIRT_CHN-1:0] grant_ready;

  // winner of this cycle's arbitration
  vc_id_t sel_ch;
  logic   sel_hit;

  // one fifo per channel
  // instance index is the channel tag
  for (genvar i = 0; i < `NUM_VIRT_CHN; i++) begin : gen_virtual_channels
    vc_buffer u_virtual_channel_fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .vc_id_i (vc_id_t'(i)),
      // payload is broadcast, valid picks the lane
      .fdata_i (fin_req_i.fdata),
      .valid_i (demux_valid[i]),
      .ready_o (demux_ready[i]),
      .fdata_o (to_output_req[i].fdata),
      .vc_id_o (to_output_req[i].vc_id),
      .valid_o (to_output_req[i].valid),
      .ready_i (grant_ready[i])
    );
  end

  // input demux
  // steer valid to the tagged fifo and return its ready
  always_comb begin : input_demux
    demux_valid      = '0;
    fin_resp_o       = '0;
    // unknown tag, accept and drop the flit
    fin_resp_o.ready = 1'b1;
    if (int'(fin_req_i.vc_id) < `NUM_VIRT_CHN) begin
      demux_valid[fin_req_i.vc_id] = fin_req_i.valid;
      fin_resp_o.ready             = demux_ready[fin_req_i.vc_id];
    end
  end

  // output mux
  // fixed priority, first valid in scan order wins
  always_comb begin : output_mux
    int idx;
    fout_req_o  = '0;
    grant_ready = '0;
    sel_ch      = '0;
    sel_hit     = 1'b0;
    // scan from the favoured end
    for (int i = 0; i < `NUM_VIRT_CHN; i++) begin
      idx = HIGH_PRIO_TOP ? (`NUM_VIRT_CHN - 1 - i) : i;
      if (to_output_req[idx].valid && !sel_hit) begin
        sel_hit = 1'b1;
        sel_ch  = vc_id_t'(idx);
      end
    end
    // nobody valid, request stays all zero
    if (sel_hit) begin
      fout_req_o = to_output_req[sel_ch];
      // losers see ready low and hold their head
      grant_ready[sel_ch] = fout_resp_i.ready;
    end
  end

endmodule

`default_nettype wire

/* verilog/noc_config.svh */
// defines for channel count, flit and tag widths, fifo depth and output priority
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// virtual channels per input port
// three on purpose, so tag value 3 names no channel
`define NUM_VIRT_CHN 3

// bits of a channel tag
// must hold NUM_VIRT_CHN-1
`define VC_WIDTH 2

// payload bits of one flit
`define FLIT_WIDTH 32

// entries per channel fifo
// keep a power of two, pointers wrap on their own
`define VC_FIFO_DEPTH 4

// output arbitration direction
// 1 means highest-numbered channel wins
// 0 means channel 0 wins
`define HIGH_PRIO_ZERO_LOW 1

// worst case flits held inside one port
// all fifos full plus both skid entries
`define PORT_MAX_FLITS ((`NUM_VIRT_CHN * `VC_FIFO_DEPTH) + 2)

`endif

/* verilog/noc_input_port.sv */
// router input port top module joining the channel datapath to the output skid buffer
`timescale 1ns/1ps
`default_nettype none

module noc_input_port (
  input  logic                clk,
  input  logic                rst_i,
  // external sender
  input  noc_pkg::flit_req_t  fin_req_i,
  output noc_pkg::flit_resp_t fin_resp_o,
  // downstream link, driven from flops
  output noc_pkg::flit_req_t  fout_req_o,
  input  noc_pkg::flit_resp_t fout_resp_i
);
  import noc_pkg::*;

  // datapath to skid buffer link
  flit_req_t  dp_req;
  flit_resp_t dp_resp;

  // demux, channel fifos and arbiter
  // adds one cycle through the fifo
  input_datapath u_input_datapath (
    .clk         (clk),
    .rst_i       (rst_i),
    .fin_req_i   (fin_req_i),
    .fin_resp_o  (fin_resp_o),
    .fout_req_o  (dp_req),
    .fout_resp_i (dp_resp)
  );

  // registered output stage
  // second cycle of latency, absorbs link stalls
  flit_skid_buffer u_out_skid (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_req_i   (dp_req),
    .in_resp_o  (dp_resp),
    .out_req_o  (fout_req_o),
    .out_resp_i (fout_resp_i)
  );

endmodule

`default_nettype wire

/* verilog/noc_pkg.sv */
// package with flit payload and tag types and the flit link request/response structs
`default_nettype none

package noc_pkg;

  `include "noc_config.svh"

  // one payload word
  typedef logic [`FLIT_WIDTH-1:0] flit_data_t;

  // virtual channel number carried with every flit
  typedef logic [`VC_WIDTH-1:0] vc_id_t;

  // sender side of a flit link
  // fdata sits in the top bits, valid is bit 0
  typedef struct packed {
    // payload
    flit_data_t fdata;
    // channel tag
    vc_id_t     vc_id;
    // flit present, held until ready
    logic       valid;
  } flit_req_t;

  // receiver side of a flit link
  // kept as a struct so new back-channel fields
  // can be added without touching every port list
  typedef struct packed {
    // receiver takes the flit this cycle
    logic ready;
  } flit_resp_t;

  // width of a full request, handy for flattening
  localparam int FLIT_REQ_BITS = $bits(flit_req_t);

  // width of a full response
  localparam int FLIT_RESP_BITS = $bits(flit_resp_t);

endpackage

`default_nettype wire

/* verilog/vc_buffer.sv */
// per virtual channel flit fifo module with valid/ready on both sides and a fixed tag
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module vc_buffer (
  input  logic                clk,
  input  logic                rst_i,
  // channel number of this instance, tied off by parent
  input  noc_pkg::vc_id_t     vc_id_i,
  // write side
  input  noc_pkg::flit_data_t fdata_i,
  input  logic                valid_i,
  output logic                ready_o,
  // read side
  output noc_pkg::flit_data_t fdata_o,
  output noc_pkg::vc_id_t     vc_id_o,
  output logic                valid_o,
  input  logic                ready_i
);
  import noc_pkg::*;

  // index bits into the storage array
  localparam int ADDR_W = $clog2(`VC_FIFO_DEPTH);

  // storage, no reset on payload
  flit_data_t mem [`VC_FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  // same slot, different lap -> full
  assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  // same slot, same lap -> empty
  assign empty = (wr_ptr == rd_ptr);

  // full blocks a write even if a read pops this cycle
  assign wr_en = valid_i && !full;

  // pop only what is really there
  assign rd_en = ready_i && !empty;

  // pointer update
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // payload write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= fdata_i;
    end
  end

  // low only when no slot left
  assign ready_o = !full;

  // head flit, visible the cycle after its write
  assign valid_o = !empty;
  assign fdata_o = mem[rd_ptr[ADDR_W-1:0]];

  // every flit here belongs to this channel
  assign vc_id_o = vc_id_i;

endmodule

`default_nettype wire
